/* arb_if.sv */
// ----------------------------------------
// arbiter to framer link
// merged word plus its channel index
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface arb_if
    import rdo_pkg::*;
();
    logic              valid;  // may follow ready combinationally
    logic              ready;  // framer can take a word
    logic [DATA_W-1:0] data;
    logic [CH_W-1:0]   chan;   // source channel of data

    modport src (output valid, data, chan, input ready);
    modport dst (input valid, data, chan, output ready);

endinterface

`default_nettype wire

/* chan_fifo.sv */
// ----------------------------------------
// per-channel readout fifo
// circular buffer, raises write and hold
// requests towards the arbiter
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module chan_fifo
    import rdo_pkg::*;
(
    input  logic              CLK,
    input  logic              RST,
    input  logic              wr,
    input  logic [DATA_W-1:0] wr_data,
    output logic              write_req,
    output logic              hold_req,
    output logic [DATA_W-1:0] rd_data,
    input  logic              read_grant
);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;   // fill level
    logic              full;
    logic              push;
    logic              pop;

    assign full = (count == CNT_W'(FIFO_DEPTH));
    assign push = wr && !full;   // write into full fifo is lost
    assign pop  = read_grant && (count != '0);

    // requests come from the registered fill level
    assign write_req = (count != '0);
    assign hold_req  = (count >= CNT_W'(HOLD_LEVEL));  // stays up until drained below level
    assign rd_data   = mem[rd_ptr];                    // head word always visible

    always_ff @(posedge CLK) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps by itself
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

/* credit_tx.sv */
// ----------------------------------------
// credit gated transmitter
// one output word per available credit
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module credit_tx
    import rdo_pkg::*;
(
    input  logic              CLK,
    input  logic              RST,
    frame_if.dst              frm,
    input  logic              credit_ret,  // one pulse per returned credit
    output logic              out_valid,
    output logic              out_header,
    output logic [DATA_W-1:0] out_data
);

    logic [CREDIT_W-1:0] credits;
    logic                accept;

    // output register is free whenever it is not showing a word
    assign frm.ready = (credits != '0) && !out_valid;
    assign accept    = frm.valid && frm.ready;

    always_ff @(posedge CLK) begin
        if (RST)
            out_valid <= 1'b0;
        else
            out_valid <= accept;  // single cycle pulse
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            out_data   <= frm.data;
            out_header <= frm.header;
        end
    end

    // word sent costs one, credit_ret gives one back, both can coincide
    always_ff @(posedge CLK) begin
        if (RST) begin
            credits <= CREDIT_W'(NUM_CREDITS);
        end else begin
            case ({out_valid, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* frame_if.sv */
// ----------------------------------------
// framer to transmitter link
// framed stream with header flag
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface frame_if
    import rdo_pkg::*;
();
    logic              valid;   // held until accepted
    logic              ready;   // transmitter has credit and room
    logic [DATA_W-1:0] data;
    logic              header;  // data is a channel header word

    modport src (output valid, data, header, input ready);
    modport dst (input valid, data, header, output ready);

endinterface

`default_nettype wire

/* rdo_pkg.sv */
// ----------------------------------------
// readout package
// sizes, header marker and framer states
// ----------------------------------------
`default_nettype none

package rdo_pkg;

    localparam int NUM_CH      = 4;   // front-end channels
    localparam int DATA_W      = 32;  // data word width
    localparam int CH_W        = 2;   // channel index width
    localparam int FIFO_DEPTH  = 8;   // words per channel fifo
    localparam int PTR_W       = 3;   // fifo pointer width
    localparam int CNT_W       = 4;   // fill counter, holds 0..FIFO_DEPTH
    localparam int HOLD_LEVEL  = 6;   // fill level raising hold_req
    localparam int NUM_CREDITS = 4;   // credits after reset
    localparam int CREDIT_W    = 3;

    // upper half of a header word, low CH_W bits carry the channel
    localparam logic [15:0] HDR_MARK = 16'hA5C3;

    typedef enum logic [1:0] {
        FR_IDLE,    // waiting for a word from the arbiter
        FR_HEADER,  // presenting channel header
        FR_DATA     // presenting the held data word
    } framer_state_e;

endpackage

`default_nettype wire

/* readout_framer.sv */
// ----------------------------------------
// readout framer
// puts a channel header in front of each
// run of words from one channel
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module readout_framer
    import rdo_pkg::*;
(
    input  logic CLK,
    input  logic RST,
    arb_if.dst   arb,
    frame_if.src frm
);

    framer_state_e     state;
    logic [DATA_W-1:0] data_q;     // word held while the header goes out
    logic [CH_W-1:0]   last_chan;  // channel of the last data word
    logic              seen;       // any word since reset
    logic              accept;

    assign accept    = arb.valid && arb.ready;
    assign arb.ready = (state == FR_IDLE);  // low while presenting

    assign frm.valid  = (state != FR_IDLE);
    assign frm.header = (state == FR_HEADER);
    assign frm.data   = (state == FR_HEADER) ?
                        {HDR_MARK, {(DATA_W - $bits(HDR_MARK) - CH_W){1'b0}}, last_chan} :
                        data_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state     <= FR_IDLE;
            last_chan <= '0;
            seen      <= 1'b0;
        end else begin
            case (state)
                FR_IDLE: begin
                    if (accept) begin
                        seen      <= 1'b1;
                        last_chan <= arb.chan;
                        // new channel or first word needs a header
                        if (!seen || (arb.chan != last_chan))
                            state <= FR_HEADER;
                        else
                            state <= FR_DATA;
                    end
                end
                FR_HEADER: if (frm.ready) state <= FR_DATA;
                FR_DATA:   if (frm.ready) state <= FR_IDLE;
                default:   state <= FR_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept)
            data_q <= arb.data;
    end

endmodule

`default_nettype wire

/* readout_top.sv */
// ----------------------------------------
// readout concentrator top
// channel fifos, arbiter, framer and
// credit transmitter
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module readout_top
    import rdo_pkg::*;
(
    input  logic                          CLK,
    input  logic                          RST,
    input  logic [NUM_CH-1:0]             in_wr,
    input  logic [NUM_CH-1:0][DATA_W-1:0] in_data,
    output logic                          out_valid,
    output logic [DATA_W-1:0]             out_data,
    output logic                          out_header,
    input  logic                          credit_ret
);

    logic [NUM_CH-1:0]             write_req;
    logic [NUM_CH-1:0]             hold_req;
    logic [NUM_CH-1:0]             read_grant;
    logic [NUM_CH-1:0][DATA_W-1:0] fifo_data;

    arb_if   i_arb_bus ();
    frame_if i_frm_bus ();

    // one fifo per front-end channel
    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_fifo
        chan_fifo i_fifo (
            .CLK        (CLK),
            .RST        (RST),
            .wr         (in_wr[ch]),
            .wr_data    (in_data[ch]),
            .write_req  (write_req[ch]),
            .hold_req   (hold_req[ch]),
            .rd_data    (fifo_data[ch]),
            .read_grant (read_grant[ch])
        );
    end

    rrp_arbiter i_arb (
        .CLK        (CLK),
        .RST        (RST),
        .write_req  (write_req),
        .hold_req   (hold_req),
        .fifo_data  (fifo_data),
        .read_grant (read_grant),
        .arb        (i_arb_bus.src)
    );

    readout_framer i_framer (
        .CLK (CLK),
        .RST (RST),
        .arb (i_arb_bus.dst),
        .frm (i_frm_bus.src)
    );

    credit_tx i_tx (
        .CLK        (CLK),
        .RST        (RST),
        .frm        (i_frm_bus.dst),
        .credit_ret (credit_ret),
        .out_valid  (out_valid),
        .out_header (out_header),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

/* rrp_arbiter.sv */
// ----------------------------------------
// round-robin arbiter with priority hold
// merges the channel fifos into one word
// stream, holding fifos jump the queue
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rrp_arbiter
    import rdo_pkg::*;
(
    input  logic                           CLK,
    input  logic                           RST,
    input  logic [NUM_CH-1:0]              write_req,   // round robin requests
    input  logic [NUM_CH-1:0]              hold_req,    // lower channel wins
    input  logic [NUM_CH-1:0][DATA_W-1:0]  fifo_data,
    output logic [NUM_CH-1:0]              read_grant,
    arb_if.src                             arb
);

    logic [CH_W-1:0] prev_sel;  // last granted channel
    logic [CH_W-1:0] sel;       // current choice
    logic [CH_W-1:0] idx;
    logic            hold;      // set by a transfer, cleared once ready is back
    logic            freeze;
    logic            xfer;

    // keep the mux steady while the framer is stalled after a transfer
    assign freeze = hold && !arb.ready;

    always_comb begin
        sel = prev_sel;
        idx = prev_sel;
        if (!freeze) begin
            if (|hold_req) begin
                // lowest holding channel, scanned downwards so the last hit wins
                for (int i = NUM_CH - 1; i >= 0; i--) begin
                    if (hold_req[i])
                        sel = CH_W'(i);
                end
            end else if (|write_req) begin
                // circular scan from prev_sel + 1, prev_sel itself comes last
                for (int k = NUM_CH; k >= 1; k--) begin
                    idx = prev_sel + CH_W'(k);
                    if (write_req[idx])
                        sel = idx;
                end
            end
        end
    end

    // grant only to a requesting channel when the framer takes the word
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            read_grant[i] = (sel == CH_W'(i)) && write_req[i] && arb.ready;
        end
    end

    assign xfer      = |read_grant;   // valid and ready in the same cycle
    assign arb.valid = xfer;
    assign arb.data  = fifo_data[sel];
    assign arb.chan  = sel;

    always_ff @(posedge CLK) begin
        if (RST)
            prev_sel <= CH_W'(NUM_CH - 1);  // first scan starts at channel 0
        else if (xfer)
            prev_sel <= sel;
    end

    always_ff @(posedge CLK) begin
        if (RST)
            hold <= 1'b0;
        else if (xfer)
            hold <= 1'b1;
        else if (arb.ready)
            hold <= 1'b0;
    end

endmodule

`default_nettype wire

/* src.f */
rdo_pkg.sv
arb_if.sv
frame_if.sv
chan_fifo.sv
rrp_arbiter.sv
readout_framer.sv
credit_tx.sv
readout_top.sv
tb_readout.sv

/* tb_readout.sv */
// ----------------------------------------
// readout concentrator testbench
// reference queues per channel, credit
// return model and output checker
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_readout
    import rdo_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int TOTAL_WRITES = 12 + 12 + 11 + 8 + 200;  // words over all tests
    localparam int WATCHDOG     = TOTAL_WRITES * 40 + 500; // cycles
    localparam int MODEL_SIZE   = 256;                     // ring per channel

    logic                          CLK;
    logic                          RST;
    logic [NUM_CH-1:0]             in_wr;
    logic [NUM_CH-1:0][DATA_W-1:0] in_data;
    logic                          out_valid;
    logic [DATA_W-1:0]             out_data;
    logic                          out_header;
    logic                          credit_ret;

    logic [DATA_W-1:0] model_mem [NUM_CH][MODEL_SIZE];  // expected words
    int                head [NUM_CH];
    int                tail [NUM_CH];
    int                fill [NUM_CH];    // fifo level as the model sees it
    logic [NUM_CH-1:0] grant_seen;       // pops due at the next edge
    int                hdr_log [$];      // channels named by headers
    int                seed = 32'hace;
    int                cur_ch;           // channel of the last header
    bit                in_run;
    bit                credit_on;
    int                sent;
    int                returned;
    int                owed;             // credits not yet sent back
    int                gap;
    int                words_out;
    int                dropped;
    int                test_errors;
    int                errors;
    int                pass_cnt;
    int                fail_cnt;
    string             test_name;

    readout_top i_dut (
        .CLK        (CLK),
        .RST        (RST),
        .in_wr      (in_wr),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_header (out_header),
        .credit_ret (credit_ret)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // head of a channel queue, consumed
    function automatic logic [DATA_W-1:0] next_expected(input int ch);
        logic [DATA_W-1:0] w;
        w = model_mem[ch][head[ch] % MODEL_SIZE];
        head[ch]++;
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] header_word(input int ch);
        logic [DATA_W-1:0] w;
        w = '0;
        w[DATA_W-1 -: 16] = HDR_MARK;  // marker on top
        w[CH_W-1:0] = ch[CH_W-1:0];    // channel in the low bits
        return w;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int ch = 0; ch < NUM_CH; ch++)
            n += tail[ch] - head[ch];
        return n;
    endfunction

    task automatic count_error();
        test_errors++;
        errors++;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            count_error();
        end
    endtask

    // one cycle of writes, the model drops a word for a full fifo
    task automatic write_cycle(input logic [NUM_CH-1:0] mask);
        @(negedge CLK);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            in_wr[ch] = mask[ch];
            if (mask[ch]) begin
                in_data[ch] = $random(seed);
                if (fill[ch] < FIFO_DEPTH) begin
                    model_mem[ch][tail[ch] % MODEL_SIZE] = in_data[ch];
                    tail[ch]++;
                end else
                    dropped++;
            end
        end
    endtask

    task automatic wait_sent(input int target);
        int cycles;
        cycles = 0;
        while (sent < target && cycles < 200) begin
            @(negedge CLK);
            cycles++;
        end
        assert (sent >= target)
        else begin
            $display("error in %s: output stopped at %0d of %0d words", test_name, sent, target);
            count_error();
        end
    endtask

    // wait for empty queues and all credits home
    task automatic drain();
        int cycles;
        cycles = 0;
        while ((pending_words() != 0 || owed != 0) && cycles < 600) begin
            @(negedge CLK);
            cycles++;
        end
        assert (pending_words() == 0 && owed == 0)
        else begin
            $display("error in %s: %0d words never came out", test_name, pending_words());
            count_error();
        end
        repeat (4) @(negedge CLK);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        words_out   = 0;
        dropped     = 0;
        hdr_log.delete();
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            pass_cnt++;
            $display("test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    always @(negedge CLK)
        grant_seen <= i_dut.read_grant;  // stable mid cycle

    // fifo level follows writes and grants at the clock edge
    always @(posedge CLK) begin
        if (credit_ret)
            returned++;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (RST)
                fill[ch] = 0;
            else
                fill[ch] = fill[ch] + int'(in_wr[ch] && fill[ch] < FIFO_DEPTH)
                           - int'(grant_seen[ch]);
        end
    end

    // credit return, random gap between pulses
    initial begin
        credit_ret = 1'b0;
        gap = 1;
        forever begin
            @(negedge CLK);
            credit_ret = 1'b0;
            if (credit_on && owed > 0) begin
                if (gap == 0) begin
                    credit_ret = 1'b1;
                    owed--;
                    gap = 1 + $unsigned($random(seed)) % 4;
                end else
                    gap--;
            end
        end
    end

    always @(negedge CLK) begin : check_output
        logic [DATA_W-1:0] exp_word;
        if (!RST && out_valid === 1'b1) begin
            sent++;
            owed++;
            assert (sent - returned <= NUM_CREDITS)
            else begin
                $display("error in %s: word sent with no credit left", test_name);
                count_error();
            end
            if (out_header) begin
                cur_ch = int'(out_data[CH_W-1:0]);
                in_run = 1'b1;
                hdr_log.push_back(cur_ch);
                exp_word = header_word(cur_ch);
                assert (out_data == exp_word)
                else begin
                    $display("mismatch %s header: expected %h actual %h",
                             test_name, exp_word, out_data);
                    count_error();
                end
            end else begin
                assert (in_run && tail[cur_ch] > head[cur_ch])
                else begin
                    $display("error in %s: data word %h arrived with nothing queued",
                             test_name, out_data);
                    count_error();
                end
                if (in_run && tail[cur_ch] > head[cur_ch]) begin
                    exp_word = next_expected(cur_ch);
                    words_out++;
                    assert (out_data == exp_word)
                    else begin
                        $display("mismatch %s ch%0d data: expected %h actual %h",
                                 test_name, cur_ch, exp_word, out_data);
                        count_error();
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("error: timeout, run still busy after %0d cycles", WATCHDOG);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int base;
        int ch;
        RST       = 1'b1;
        in_wr     = '0;
        in_data   = '0;
        credit_on = 1'b1;
        for (int i = 0; i < NUM_CH; i++) begin
            head[i] = 0;
            tail[i] = 0;
        end
        repeat (10) @(negedge CLK);
        RST = 1'b0;

        start_test("single_channel");
        repeat (12) begin
            write_cycle(4'b0010);
            repeat (3) write_cycle('0);  // paced, fifo stays low
        end
        drain();
        check_value("headers", 1, hdr_log.size());
        check_value("header channel", 1, (hdr_log.size() > 0) ? hdr_log[0] : -1);
        check_value("data words", 12, words_out);
        check_value("dropped writes", 0, dropped);
        end_test();

        start_test("round_robin");
        credit_on = 1'b0;
        repeat (3) write_cycle('1);  // three words into every channel
        write_cycle('0);
        credit_on = 1'b1;
        drain();
        check_value("headers", 12, hdr_log.size());
        // channel 1 went last, scan resumes at 2
        for (int i = 0; i < hdr_log.size(); i++)
            check_value("header order", (2 + i) % NUM_CH, hdr_log[i]);
        end_test();

        start_test("priority_hold");
        credit_on = 1'b0;
        base = sent;
        repeat (3) write_cycle(4'b0100);  // header plus three words use every credit
        write_cycle('0);
        wait_sent(base + NUM_CREDITS);
        hdr_log.delete();
        write_cycle(4'b0001);
        write_cycle(4'b0010);
        repeat (HOLD_LEVEL) write_cycle(4'b1000);
        write_cycle('0);
        credit_on = 1'b1;
        drain();
        check_value("first header channel", 0, (hdr_log.size() > 0) ? hdr_log[0] : -1);
        check_value("second header channel", 3, (hdr_log.size() > 1) ? hdr_log[1] : -1);
        end_test();

        start_test("credit_limit");
        credit_on = 1'b0;
        base = sent;
        repeat (8) write_cycle(4'b0100);
        write_cycle('0);
        wait_sent(base + NUM_CREDITS);
        repeat (20) write_cycle('0);  // no credits come back here
        check_value("words without returns", NUM_CREDITS, sent - base);
        credit_on = 1'b1;
        drain();
        check_value("data words", 8, words_out);
        end_test();

        start_test("random_traffic");
        for (int n = 0; n < 200; n++) begin
            ch = $unsigned($random(seed)) % NUM_CH;
            write_cycle(NUM_CH'(1) << ch);
            if ($unsigned($random(seed)) % 4 == 0)
                repeat (1 + $unsigned($random(seed)) % 3) write_cycle('0);
        end
        write_cycle('0);
        drain();
        $display("random traffic: %0d words out, %0d writes dropped", words_out, dropped);
        end_test();

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
